// ==== build.f ====
source/floo_pkg.sv
source/floo_fifo.sv
source/floo_route_select.sv
source/floo_rr_arbiter.sv
source/floo_router.sv
source/floo_axi_router.sv
test/floo_router_checker.sv
test/tb_floo_axi_router.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the mesh node testbench with Verilator.
# The result is taken from the simulation log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_floo_axi_router \
  -f build.f \
  -o Vtb_floo_axi_router

./obj_dir/Vtb_floo_axi_router > sim.log 2>&1 || true
cat sim.log

if grep -q "^Regression passed$" sim.log; then
  exit 0
else
  exit 1
fi

// ==== source/floo_axi_router.sv ====
// Mesh node top level with separate request and response networks.
// Both networks are the same five-port router, fed with the node ID
// and their own set of valid/ready links.

`timescale 1ns/1ns
`default_nettype none

module floo_axi_router (
  input  logic                                                   clk_i,
  input  logic                                                   rst_n_i,
  input  logic [floo_pkg::IdWidth-1:0]                           id_i,
  // Request network
  input  logic [floo_pkg::NumPorts-1:0]                          req_valid_i,
  output logic [floo_pkg::NumPorts-1:0]                          req_ready_o,
  input  logic [floo_pkg::NumPorts-1:0][floo_pkg::FlitWidth-1:0] req_data_i,
  output logic [floo_pkg::NumPorts-1:0]                          req_valid_o,
  input  logic [floo_pkg::NumPorts-1:0]                          req_ready_i,
  output logic [floo_pkg::NumPorts-1:0][floo_pkg::FlitWidth-1:0] req_data_o,
  // Response network
  input  logic [floo_pkg::NumPorts-1:0]                          rsp_valid_i,
  output logic [floo_pkg::NumPorts-1:0]                          rsp_ready_o,
  input  logic [floo_pkg::NumPorts-1:0][floo_pkg::FlitWidth-1:0] rsp_data_i,
  output logic [floo_pkg::NumPorts-1:0]                          rsp_valid_o,
  input  logic [floo_pkg::NumPorts-1:0]                          rsp_ready_i,
  output logic [floo_pkg::NumPorts-1:0][floo_pkg::FlitWidth-1:0] rsp_data_o
);

  floo_router i_req_floo_router (
    .clk_i   ( clk_i       ),
    .rst_n_i ( rst_n_i     ),
    .id_i    ( id_i        ),
    .valid_i ( req_valid_i ),
    .ready_o ( req_ready_o ),
    .data_i  ( req_data_i  ),
    .valid_o ( req_valid_o ),
    .ready_i ( req_ready_i ),
    .data_o  ( req_data_o  )
  );

  // Responses travel on their own network to avoid protocol deadlock
  floo_router i_rsp_floo_router (
    .clk_i   ( clk_i       ),
    .rst_n_i ( rst_n_i     ),
    .id_i    ( id_i        ),
    .valid_i ( rsp_valid_i ),
    .ready_o ( rsp_ready_o ),
    .data_i  ( rsp_data_i  ),
    .valid_o ( rsp_valid_o ),
    .ready_i ( rsp_ready_i ),
    .data_o  ( rsp_data_o  )
  );

endmodule

`default_nettype wire

// ==== source/floo_fifo.sv ====
// Input flit buffer of one router port.
// Circular buffer with valid/ready on both sides, no fall-through:
// a flit pushed on one edge shows at the head after that edge.

`timescale 1ns/1ns
`default_nettype none

module floo_fifo (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  // Upstream link
  input  logic                           valid_i,
  output logic                           ready_o,
  input  logic [floo_pkg::FlitWidth-1:0] data_i,
  // Head of the buffer
  output logic                           valid_o,
  input  logic                           ready_i,
  output logic [floo_pkg::FlitWidth-1:0] data_o
);

  logic [floo_pkg::FlitWidth-1:0]      mem [floo_pkg::InFifoDepth];
  logic [floo_pkg::InFifoPtrWidth-1:0] wr_ptr_q;
  logic [floo_pkg::InFifoPtrWidth-1:0] rd_ptr_q;
  logic [floo_pkg::InFifoCntWidth-1:0] count_q;
  logic                                push;
  logic                                pop;

  assign ready_o = (count_q != floo_pkg::InFifoFull);
  assign valid_o = (count_q != '0);
  assign data_o  = mem[rd_ptr_q];

  assign push = valid_i & ready_o;
  assign pop  = valid_o & ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == floo_pkg::InFifoLastPtr) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == floo_pkg::InFifoLastPtr) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop keep the occupancy
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  // Occupancy stays within the depth, pointers meet only when empty or full
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (count_q <= floo_pkg::InFifoFull) &&
    ((wr_ptr_q == rd_ptr_q) == (count_q == '0 || count_q == floo_pkg::InFifoFull)));

endmodule

`default_nettype wire

// ==== source/floo_pkg.sv ====
// Shared constants for the mesh router: flit layout, port indices,
// coordinate widths and input buffer sizing.
// RTL, checker and testbench refer to these by floo_pkg:: scoped names.

`default_nettype none

package floo_pkg;

  // Ports of one network
  localparam int unsigned NumPorts     = 5;
  localparam int unsigned PortIdxWidth = $clog2(NumPorts);
  localparam logic [PortIdxWidth-1:0] PortIdxMax = PortIdxWidth'(NumPorts - 1);

  localparam int unsigned PortLocal = 0;
  localparam int unsigned PortNorth = 1;
  localparam int unsigned PortEast  = 2;
  localparam int unsigned PortSouth = 3;
  localparam int unsigned PortWest  = 4;

  // Node coordinates, the ID is {x, y}
  localparam int unsigned CoordWidth = 2;
  localparam int unsigned IdWidth    = 2 * CoordWidth;
  localparam int unsigned IdYLsb     = 0;
  localparam int unsigned IdXLsb     = CoordWidth;

  // Header fields in the low flit bits
  localparam int unsigned DstXLsb = 0;
  localparam int unsigned DstYLsb = DstXLsb + CoordWidth;
  localparam int unsigned SrcXLsb = DstYLsb + CoordWidth;
  localparam int unsigned SrcYLsb = SrcXLsb + CoordWidth;
  localparam int unsigned LastBit = SrcYLsb + CoordWidth;

  // Payload above the header
  localparam int unsigned PayloadLsb   = LastBit + 1;
  localparam int unsigned PayloadWidth = 20;
  localparam int unsigned FlitWidth    = PayloadLsb + PayloadWidth;

  // Input buffer
  localparam int unsigned InFifoDepth    = 2;
  localparam int unsigned InFifoPtrWidth = (InFifoDepth > 1) ? $clog2(InFifoDepth) : 1;
  localparam int unsigned InFifoCntWidth = $clog2(InFifoDepth + 1);
  localparam logic [InFifoPtrWidth-1:0] InFifoLastPtr = InFifoPtrWidth'(InFifoDepth - 1);
  localparam logic [InFifoCntWidth-1:0] InFifoFull    = InFifoCntWidth'(InFifoDepth);

endpackage

`default_nettype wire

// ==== source/floo_route_select.sv ====
// Dimension-ordered XY routing of one input port.
// Compares the header destination with the node ID and
// requests exactly one output port, X is resolved before Y.

`timescale 1ns/1ns
`default_nettype none

module floo_route_select (
  input  logic [floo_pkg::IdWidth-1:0]   id_i,
  input  logic [floo_pkg::FlitWidth-1:0] data_i,
  output logic [floo_pkg::NumPorts-1:0]  port_req_o
);

  logic [floo_pkg::CoordWidth-1:0] dst_x;
  logic [floo_pkg::CoordWidth-1:0] dst_y;
  logic [floo_pkg::CoordWidth-1:0] node_x;
  logic [floo_pkg::CoordWidth-1:0] node_y;

  assign dst_x  = data_i[floo_pkg::DstXLsb +: floo_pkg::CoordWidth];
  assign dst_y  = data_i[floo_pkg::DstYLsb +: floo_pkg::CoordWidth];
  assign node_x = id_i[floo_pkg::IdXLsb +: floo_pkg::CoordWidth];
  assign node_y = id_i[floo_pkg::IdYLsb +: floo_pkg::CoordWidth];

  always_comb begin
    port_req_o = '0;
    if (dst_x > node_x) begin
      port_req_o[floo_pkg::PortEast] = 1'b1;
    end else if (dst_x < node_x) begin
      port_req_o[floo_pkg::PortWest] = 1'b1;
    end else if (dst_y > node_y) begin
      // Y grows towards north
      port_req_o[floo_pkg::PortNorth] = 1'b1;
    end else if (dst_y < node_y) begin
      port_req_o[floo_pkg::PortSouth] = 1'b1;
    end else begin
      port_req_o[floo_pkg::PortLocal] = 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== source/floo_router.sv ====
// One physical network of the mesh node with five ports.
// Input fifos feed XY route selects, one round-robin arbiter per output
// picks a fifo head and the crossbar passes it on, wormhole style.

`timescale 1ns/1ns
`default_nettype none

module floo_router (
  input  logic                                                clk_i,
  input  logic                                                rst_n_i,
  input  logic [floo_pkg::IdWidth-1:0]                        id_i,
  // Incoming links
  input  logic [floo_pkg::NumPorts-1:0]                       valid_i,
  output logic [floo_pkg::NumPorts-1:0]                       ready_o,
  input  logic [floo_pkg::NumPorts-1:0][floo_pkg::FlitWidth-1:0] data_i,
  // Outgoing links
  output logic [floo_pkg::NumPorts-1:0]                       valid_o,
  input  logic [floo_pkg::NumPorts-1:0]                       ready_i,
  output logic [floo_pkg::NumPorts-1:0][floo_pkg::FlitWidth-1:0] data_o
);

  // Fifo heads
  logic [floo_pkg::NumPorts-1:0]                          fifo_valid;
  logic [floo_pkg::NumPorts-1:0]                          fifo_pop;
  logic [floo_pkg::NumPorts-1:0][floo_pkg::FlitWidth-1:0] fifo_data;
  logic [floo_pkg::NumPorts-1:0]                          fifo_last;

  // Indexed [input][output]
  logic [floo_pkg::NumPorts-1:0][floo_pkg::NumPorts-1:0] route_req;
  logic [floo_pkg::NumPorts-1:0][floo_pkg::NumPorts-1:0] in_gnt;

  // Indexed [output][input]
  logic [floo_pkg::NumPorts-1:0][floo_pkg::NumPorts-1:0] out_req;
  logic [floo_pkg::NumPorts-1:0][floo_pkg::NumPorts-1:0] out_gnt;

  for (genvar i = 0; i < floo_pkg::NumPorts; i++) begin : gen_in
    floo_fifo i_floo_fifo (
      .clk_i   ( clk_i         ),
      .rst_n_i ( rst_n_i       ),
      .valid_i ( valid_i[i]    ),
      .ready_o ( ready_o[i]    ),
      .data_i  ( data_i[i]     ),
      .valid_o ( fifo_valid[i] ),
      .ready_i ( fifo_pop[i]   ),
      .data_o  ( fifo_data[i]  )
    );

    floo_route_select i_floo_route_select (
      .id_i       ( id_i         ),
      .data_i     ( fifo_data[i] ),
      .port_req_o ( route_req[i] )
    );

    assign fifo_last[i] = fifo_data[i][floo_pkg::LastBit];

    for (genvar o = 0; o < floo_pkg::NumPorts; o++) begin : gen_xpose
      assign out_req[o][i] = fifo_valid[i] & route_req[i][o];
      assign in_gnt[i][o]  = out_gnt[o][i];
    end

    // Head leaves when its granted output takes it
    assign fifo_pop[i] = |(in_gnt[i] & ready_i);

    a_single_owner: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(in_gnt[i]));

    // Traffic on the Y axis has already resolved X
    if (i == floo_pkg::PortNorth || i == floo_pkg::PortSouth) begin : gen_y_check
      a_no_turn_to_x: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fifo_valid[i] |-> !(route_req[i][floo_pkg::PortEast] ||
                            route_req[i][floo_pkg::PortWest]));
    end
  end

  for (genvar o = 0; o < floo_pkg::NumPorts; o++) begin : gen_out
    logic [floo_pkg::FlitWidth-1:0] mux_data;

    floo_rr_arbiter i_floo_rr_arbiter (
      .clk_i   ( clk_i      ),
      .rst_n_i ( rst_n_i    ),
      .req_i   ( out_req[o] ),
      .last_i  ( fifo_last  ),
      .ready_i ( ready_i[o] ),
      .gnt_o   ( out_gnt[o] ),
      .valid_o ( valid_o[o] )
    );

    // AND-OR crossbar column, the grant is at most one-hot
    always_comb begin
      mux_data = '0;
      for (int unsigned i = 0; i < floo_pkg::NumPorts; i++) begin
        if (out_gnt[o][i]) begin
          mux_data = mux_data | fifo_data[i];
        end
      end
    end

    assign data_o[o] = mux_data;
  end

endmodule

`default_nettype wire

// ==== source/floo_rr_arbiter.sv ====
// Round-robin arbiter of one router output.
// Picks the first requester at or after the priority pointer and locks
// onto it until the last flit of its packet has been accepted.

`timescale 1ns/1ns
`default_nettype none

module floo_rr_arbiter (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic [floo_pkg::NumPorts-1:0] req_i,
  input  logic [floo_pkg::NumPorts-1:0] last_i,
  input  logic                          ready_i,
  output logic [floo_pkg::NumPorts-1:0] gnt_o,
  output logic                          valid_o
);

  logic [floo_pkg::PortIdxWidth-1:0] prio_q;
  logic [floo_pkg::PortIdxWidth-1:0] lock_idx_q;
  logic                              lock_q;
  logic [floo_pkg::PortIdxWidth-1:0] rr_idx;
  logic                              rr_found;
  logic [floo_pkg::PortIdxWidth-1:0] win_idx;
  logic                              win_last;
  logic                              xfer;

  // Search from the pointer upwards with wrap-around
  always_comb begin
    int unsigned idx;
    rr_found = 1'b0;
    rr_idx   = '0;
    for (int unsigned off = 0; off < floo_pkg::NumPorts; off++) begin
      idx = (32'(prio_q) + off) % floo_pkg::NumPorts;
      if (!rr_found && req_i[idx]) begin
        rr_found = 1'b1;
        rr_idx   = idx[floo_pkg::PortIdxWidth-1:0];
      end
    end
  end

  always_comb begin
    gnt_o = '0;
    if (lock_q) begin
      // Mid-packet the locked input may be briefly empty
      gnt_o[lock_idx_q] = req_i[lock_idx_q];
    end else if (rr_found) begin
      gnt_o[rr_idx] = 1'b1;
    end
  end

  assign valid_o  = |gnt_o;
  assign win_idx  = lock_q ? lock_idx_q : rr_idx;
  assign win_last = last_i[win_idx];
  assign xfer     = valid_o & ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      prio_q     <= '0;
      lock_idx_q <= '0;
      lock_q     <= 1'b0;
    end else if (xfer && win_last) begin
      lock_q <= 1'b0;
      prio_q <= (win_idx == floo_pkg::PortIdxMax) ? '0 : win_idx + 1'b1;
    end else if (valid_o) begin
      // Hold the choice through the packet and while stalled
      lock_q     <= 1'b1;
      lock_idx_q <= win_idx;
    end
  end

  a_gnt_onehot0: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(gnt_o));

  // A stalled offer stays on the same input
  a_gnt_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(gnt_o));

endmodule

`default_nettype wire

// ==== test/floo_router_checker.sv ====
// Scoreboard for both networks of the mesh node.
// Records every accepted input flit in a queue per network, input and
// output, matches output flits against them, bounds the round-robin
// wait of each input head and counts the errors.

`timescale 1ns/1ns
`default_nettype none

module floo_router_checker (
  input  logic                                                   clk_i,
  input  logic                                                   rst_n_i,
  input  logic [floo_pkg::IdWidth-1:0]                           id_i,
  input  logic [floo_pkg::NumPorts-1:0]                          req_in_valid_i,
  input  logic [floo_pkg::NumPorts-1:0]                          req_in_ready_i,
  input  logic [floo_pkg::NumPorts-1:0][floo_pkg::FlitWidth-1:0] req_in_data_i,
  input  logic [floo_pkg::NumPorts-1:0]                          req_out_valid_i,
  input  logic [floo_pkg::NumPorts-1:0]                          req_out_ready_i,
  input  logic [floo_pkg::NumPorts-1:0][floo_pkg::FlitWidth-1:0] req_out_data_i,
  input  logic [floo_pkg::NumPorts-1:0]                          rsp_in_valid_i,
  input  logic [floo_pkg::NumPorts-1:0]                          rsp_in_ready_i,
  input  logic [floo_pkg::NumPorts-1:0][floo_pkg::FlitWidth-1:0] rsp_in_data_i,
  input  logic [floo_pkg::NumPorts-1:0]                          rsp_out_valid_i,
  input  logic [floo_pkg::NumPorts-1:0]                          rsp_out_ready_i,
  input  logic [floo_pkg::NumPorts-1:0][floo_pkg::FlitWidth-1:0] rsp_out_data_i,
  output int unsigned                                            err_cnt_o,
  output int unsigned                                            pending_o
);

  // Indexed [network][input][output]
  logic [floo_pkg::FlitWidth-1:0] exp_q [2][floo_pkg::NumPorts][floo_pkg::NumPorts][$];
  // Open packet on each output, tagged by input and packet number
  logic                           owner_vld    [2][floo_pkg::NumPorts];
  logic [10:0]                    owner_tag    [2][floo_pkg::NumPorts];
  logic                           stall_q      [2][floo_pkg::NumPorts];
  logic [floo_pkg::FlitWidth-1:0] stall_data_q [2][floo_pkg::NumPorts];
  // Output wanted by each undelivered flit of an input, oldest first
  int unsigned                    head_q       [2][floo_pkg::NumPorts][$];
  int unsigned                    wait_cnt     [2][floo_pkg::NumPorts];
  logic                           reset_seen;

  // XY rule: X first, east for larger x, north for larger y
  function automatic int unsigned expected_port(input logic [floo_pkg::FlitWidth-1:0] flit,
                                                input logic [floo_pkg::IdWidth-1:0] id);
    int dx;
    int dy;
    dx = int'(flit[floo_pkg::DstXLsb +: floo_pkg::CoordWidth]) -
         int'(id[floo_pkg::IdXLsb +: floo_pkg::CoordWidth]);
    dy = int'(flit[floo_pkg::DstYLsb +: floo_pkg::CoordWidth]) -
         int'(id[floo_pkg::IdYLsb +: floo_pkg::CoordWidth]);
    if (dx > 0) return floo_pkg::PortEast;
    if (dx < 0) return floo_pkg::PortWest;
    if (dy > 0) return floo_pkg::PortNorth;
    if (dy < 0) return floo_pkg::PortSouth;
    return floo_pkg::PortLocal;
  endfunction

  task automatic report_mismatch(input string msg);
    $display("MISMATCH at %0t ns: %s", $time, msg);
    err_cnt_o++;
  endtask

  task automatic observe_network(
    input int                                                   net,
    input logic [floo_pkg::NumPorts-1:0]                          in_valid,
    input logic [floo_pkg::NumPorts-1:0]                          in_ready,
    input logic [floo_pkg::NumPorts-1:0][floo_pkg::FlitWidth-1:0] in_data,
    input logic [floo_pkg::NumPorts-1:0]                          out_valid,
    input logic [floo_pkg::NumPorts-1:0]                          out_ready,
    input logic [floo_pkg::NumPorts-1:0][floo_pkg::FlitWidth-1:0] out_data
  );
    logic [floo_pkg::FlitWidth-1:0] flit;
    logic [floo_pkg::FlitWidth-1:0] exp_flit;
    logic [10:0]                    tag;
    int unsigned                    src;
    int unsigned                    dst;
    for (int p = 0; p < floo_pkg::NumPorts; p++) begin
      if (in_valid[p] && in_ready[p]) begin
        dst = expected_port(in_data[p], id_i);
        exp_q[net][p][dst].push_back(in_data[p]);
        head_q[net][p].push_back(dst);
        pending_o++;
      end
    end
    for (int o = 0; o < floo_pkg::NumPorts; o++) begin
      // A stalled offer must stay put
      if (stall_q[net][o] && (!out_valid[o] || out_data[o] != stall_data_q[net][o])) begin
        report_mismatch($sformatf("net %0d out %0d changed while stalled", net, o));
      end
      stall_q[net][o]      = out_valid[o] && !out_ready[o];
      stall_data_q[net][o] = out_data[o];
      if (out_valid[o] && out_ready[o]) begin
        flit = out_data[o];
        tag  = flit[floo_pkg::PayloadLsb +: 11];
        src  = int'(flit[floo_pkg::PayloadLsb +: 3]);
        if (src >= floo_pkg::NumPorts) begin
          report_mismatch($sformatf("net %0d out %0d bad input index %0d", net, o, src));
        end else if (exp_q[net][src][o].size() == 0) begin
          report_mismatch($sformatf("net %0d out %0d unexpected flit %h", net, o, flit));
        end else begin
          exp_flit = exp_q[net][src][o].pop_front();
          pending_o--;
          if (exp_flit != flit) begin
            report_mismatch($sformatf("net %0d out %0d expected %h got %h",
                                      net, o, exp_flit, flit));
          end
        end
        if (src < floo_pkg::NumPorts) begin
          if (head_q[net][src].size() != 0) begin
            void'(head_q[net][src].pop_front());
          end
          wait_cnt[net][src] = 0;
          if (flit[floo_pkg::LastBit]) begin
            // Round-robin passes at most one packet of every other input
            for (int k = 0; k < floo_pkg::NumPorts; k++) begin
              if (k != src && head_q[net][k].size() != 0 && head_q[net][k][0] == o) begin
                wait_cnt[net][k]++;
                if (wait_cnt[net][k] > floo_pkg::NumPorts - 1) begin
                  report_mismatch($sformatf("net %0d out %0d input %0d waited past %0d packets",
                                            net, o, k, floo_pkg::NumPorts - 1));
                end
              end
            end
          end
        end
        if (owner_vld[net][o] && owner_tag[net][o] != tag) begin
          report_mismatch($sformatf("net %0d out %0d packets interleaved", net, o));
        end
        owner_vld[net][o] = !flit[floo_pkg::LastBit];
        owner_tag[net][o] = tag;
      end
    end
  endtask

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      reset_seen = 1'b0;
      err_cnt_o  = 0;
      pending_o  = 0;
      for (int n = 0; n < 2; n++) begin
        for (int o = 0; o < floo_pkg::NumPorts; o++) begin
          owner_vld[n][o] = 1'b0;
          stall_q[n][o]   = 1'b0;
          wait_cnt[n][o]  = 0;
        end
      end
    end else begin
      if (!reset_seen) begin
        reset_seen = 1'b1;
        if (req_out_valid_i != '0 || rsp_out_valid_i != '0) begin
          report_mismatch("valid_o high right after reset");
        end
        if (!(&req_in_ready_i) || !(&rsp_in_ready_i)) begin
          report_mismatch("input ready_o low right after reset");
        end
      end
      observe_network(0, req_in_valid_i, req_in_ready_i, req_in_data_i,
                      req_out_valid_i, req_out_ready_i, req_out_data_i);
      observe_network(1, rsp_in_valid_i, rsp_in_ready_i, rsp_in_data_i,
                      rsp_out_valid_i, rsp_out_ready_i, rsp_out_data_i);
    end
  end

endmodule

`default_nettype wire

// ==== test/tb_floo_axi_router.sv ====
// Testbench for the two-network mesh node at position x 1, y 1.
// Sends a table of packets on all ten input links at once, applies
// random back-pressure on the outputs and lets the checker compare.

`timescale 1ns/1ns
`default_nettype none

module tb_floo_axi_router;

  localparam int unsigned W       = floo_pkg::FlitWidth;
  localparam int unsigned NumRows = 20;

  // Row layout: net [10], input port [9:7], dst x [6:5], dst y [4:3], length [2:0]
  // North and south inputs keep dst x = 1 since X is already resolved upstream
  localparam logic [10:0] StimTable [NumRows] = '{
    {1'b0, 3'd0, 2'd3, 2'd1, 3'd3}, {1'b0, 3'd0, 2'd1, 2'd1, 3'd2},
    {1'b0, 3'd1, 2'd1, 2'd0, 3'd4}, {1'b0, 3'd1, 2'd1, 2'd1, 3'd1},
    {1'b0, 3'd2, 2'd0, 2'd2, 3'd2}, {1'b0, 3'd2, 2'd1, 2'd1, 3'd3},
    {1'b0, 3'd3, 2'd1, 2'd3, 3'd2}, {1'b0, 3'd3, 2'd1, 2'd1, 3'd2},
    {1'b0, 3'd4, 2'd2, 2'd0, 3'd4}, {1'b0, 3'd4, 2'd1, 2'd1, 3'd1},
    {1'b0, 3'd4, 2'd1, 2'd2, 3'd2}, {1'b0, 3'd0, 2'd1, 2'd3, 3'd1},
    {1'b1, 3'd0, 2'd0, 2'd0, 3'd2}, {1'b1, 3'd1, 2'd1, 2'd1, 3'd3},
    {1'b1, 3'd2, 2'd1, 2'd0, 3'd1}, {1'b1, 3'd3, 2'd1, 2'd2, 3'd4},
    {1'b1, 3'd4, 2'd3, 2'd3, 3'd2}, {1'b1, 3'd2, 2'd1, 2'd1, 3'd2},
    {1'b1, 3'd0, 2'd1, 2'd0, 3'd1}, {1'b1, 3'd4, 2'd1, 2'd1, 3'd3}
  };

  logic                                 clk = 1'b0;
  logic                                 rst_n;
  logic [31:0]                          rng_state = 32'h2db9_2633;
  wire  [floo_pkg::IdWidth-1:0]         node_id = {2'd1, 2'd1};
  wire  [floo_pkg::NumPorts-1:0]        req_valid_in;
  wire  [floo_pkg::NumPorts-1:0]        req_ready_in;
  wire  [floo_pkg::NumPorts-1:0][W-1:0] req_data_in;
  wire  [floo_pkg::NumPorts-1:0]        req_valid_out;
  logic [floo_pkg::NumPorts-1:0]        req_ready_out = '1;
  wire  [floo_pkg::NumPorts-1:0][W-1:0] req_data_out;
  wire  [floo_pkg::NumPorts-1:0]        rsp_valid_in;
  wire  [floo_pkg::NumPorts-1:0]        rsp_ready_in;
  wire  [floo_pkg::NumPorts-1:0][W-1:0] rsp_data_in;
  wire  [floo_pkg::NumPorts-1:0]        rsp_valid_out;
  logic [floo_pkg::NumPorts-1:0]        rsp_ready_out = '1;
  wire  [floo_pkg::NumPorts-1:0][W-1:0] rsp_data_out;
  wire  [2*floo_pkg::NumPorts-1:0]      link_done;
  int unsigned                          err_cnt;
  int unsigned                          pending;

  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int unsigned total_flits();
    int unsigned sum;
    sum = 0;
    for (int r = 0; r < NumRows; r++) begin
      sum += int'(StimTable[r][2:0]);
    end
    return sum;
  endfunction

  // Source sits one hop away in the direction of the input port
  function automatic logic [W-1:0] make_flit(input int unsigned port, input logic [10:0] row,
                                             input int unsigned pkt, input int unsigned num);
    logic [W-1:0] flit;
    logic [1:0]   src_x;
    logic [1:0]   src_y;
    flit  = '0;
    src_x = 2'd1;
    src_y = 2'd1;
    case (port)
      floo_pkg::PortNorth: src_y = 2'd2;
      floo_pkg::PortEast:  src_x = 2'd2;
      floo_pkg::PortSouth: src_y = 2'd0;
      floo_pkg::PortWest:  src_x = 2'd0;
      default: ;
    endcase
    flit[floo_pkg::DstXLsb +: 2]         = row[6:5];
    flit[floo_pkg::DstYLsb +: 2]         = row[4:3];
    flit[floo_pkg::SrcXLsb +: 2]         = src_x;
    flit[floo_pkg::SrcYLsb +: 2]         = src_y;
    flit[floo_pkg::LastBit]              = (num + 1 == int'(row[2:0]));
    flit[floo_pkg::PayloadLsb +: 3]      = port[2:0];
    flit[floo_pkg::PayloadLsb + 3 +: 8]  = pkt[7:0];
    flit[floo_pkg::PayloadLsb + 11 +: 2] = num[1:0];
    return flit;
  endfunction

  // One driver per link, taking that link's rows in table order
  for (genvar n = 0; n < 2; n++) begin : gen_net
    for (genvar p = 0; p < floo_pkg::NumPorts; p++) begin : gen_link
      logic         valid;
      logic [W-1:0] data;
      logic         done;
      wire          ready;

      if (n == 0) begin : gen_req
        assign req_valid_in[p] = valid;
        assign req_data_in[p]  = data;
        assign ready           = req_ready_in[p];
      end else begin : gen_rsp
        assign rsp_valid_in[p] = valid;
        assign rsp_data_in[p]  = data;
        assign ready           = rsp_ready_in[p];
      end
      assign link_done[n * floo_pkg::NumPorts + p] = done;

      initial begin
        valid = 1'b0;
        data  = '0;
        done  = 1'b0;
        wait (rst_n);
        for (int r = 0; r < NumRows; r++) begin
          if (int'(StimTable[r][10]) == n && int'(StimTable[r][9:7]) == p) begin
            for (int f = 0; f < int'(StimTable[r][2:0]); f++) begin
              @(posedge clk);
              #1;
              valid = 1'b1;
              data  = make_flit(p, StimTable[r], r, f);
              // Ready only moves on edges, so mid-cycle is a stable view
              @(negedge clk);
              while (!ready) @(negedge clk);
            end
          end
        end
        @(posedge clk);
        #1;
        valid = 1'b0;
        done  = 1'b1;
      end
    end
  end

  // Output back-pressure, each ready high three cycles in four on average
  always @(posedge clk) begin
    #1;
    rng_state = xorshift32(rng_state);
    for (int p = 0; p < floo_pkg::NumPorts; p++) begin
      req_ready_out[p] = ~(rng_state[2*p] & rng_state[2*p+1]);
      rsp_ready_out[p] = ~(rng_state[2*p+10] & rng_state[2*p+11]);
    end
  end

  floo_axi_router i_floo_axi_router (
    .clk_i       ( clk           ),
    .rst_n_i     ( rst_n         ),
    .id_i        ( node_id       ),
    .req_valid_i ( req_valid_in  ),
    .req_ready_o ( req_ready_in  ),
    .req_data_i  ( req_data_in   ),
    .req_valid_o ( req_valid_out ),
    .req_ready_i ( req_ready_out ),
    .req_data_o  ( req_data_out  ),
    .rsp_valid_i ( rsp_valid_in  ),
    .rsp_ready_o ( rsp_ready_in  ),
    .rsp_data_i  ( rsp_data_in   ),
    .rsp_valid_o ( rsp_valid_out ),
    .rsp_ready_i ( rsp_ready_out ),
    .rsp_data_o  ( rsp_data_out  )
  );

  floo_router_checker i_floo_router_checker (
    .clk_i           ( clk           ),
    .rst_n_i         ( rst_n         ),
    .id_i            ( node_id       ),
    .req_in_valid_i  ( req_valid_in  ),
    .req_in_ready_i  ( req_ready_in  ),
    .req_in_data_i   ( req_data_in   ),
    .req_out_valid_i ( req_valid_out ),
    .req_out_ready_i ( req_ready_out ),
    .req_out_data_i  ( req_data_out  ),
    .rsp_in_valid_i  ( rsp_valid_in  ),
    .rsp_in_ready_i  ( rsp_ready_in  ),
    .rsp_in_data_i   ( rsp_data_in   ),
    .rsp_out_valid_i ( rsp_valid_out ),
    .rsp_out_ready_i ( rsp_ready_out ),
    .rsp_out_data_i  ( rsp_data_out  ),
    .err_cnt_o       ( err_cnt       ),
    .pending_o       ( pending       )
  );

  initial begin
    rst_n = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    wait (&link_done);
    wait (pending == 0);
    repeat (4) @(posedge clk);
    $display("Errors: %0d mismatches, %0d flits undelivered", err_cnt, pending);
    if (err_cnt == 0 && pending == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin
    int unsigned limit;
    limit = total_flits() * 40 + 200;
    repeat (limit) @(posedge clk);
    $display("Timeout: traffic did not drain within %0d cycles", limit);
    $display("Errors: %0d mismatches, %0d flits undelivered", err_cnt, pending);
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire
